// ==== source/rv_pkg.sv ====
package rv_pkg;

   localparam int XLEN = 32;

   // major opcodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [2:0] F3_BEQ     = 3'b000;
   localparam logic [2:0] F3_BNE     = 3'b001;
   localparam logic [2:0] F3_WORD    = 3'b010; // lw / sw

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_SUB  = 7'b0100000;

   // stores here go to the uart, not to memory
   localparam logic [31:0] UART_ADDR = 32'h0000_F000;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASS_B
   } alu_op_t;

   typedef enum logic [1:0] {FWD_REG, FWD_EX, FWD_MEM} fwd_sel_t;

endpackage

// ==== source/pipe_if.sv ====
`timescale 1ns/1ps

interface id_ex_if;
   logic valid;
   logic [rv_pkg::XLEN-1:0] pc;
   rv_pkg::alu_op_t alu_op;
   logic [rv_pkg::XLEN-1:0] op_a, op_b, imm, store_data;
   logic [4:0] rs1, rs2, rd; // rs fields are zero when unused
   logic reg_we, mem_re, mem_we, mem_to_reg;
   logic branch_en, branch_ne, jal_en;

   modport source (output valid, pc, alu_op, op_a, op_b, imm, store_data, rs1, rs2, rd,
                   reg_we, mem_re, mem_we, mem_to_reg, branch_en, branch_ne, jal_en);
   modport sink (input valid, pc, alu_op, op_a, op_b, imm, store_data, rs1, rs2, rd,
                 reg_we, mem_re, mem_we, mem_to_reg, branch_en, branch_ne, jal_en);
endinterface

interface ex_mem_if;
   logic valid;
   logic [rv_pkg::XLEN-1:0] alu_result; // also the memory address
   logic [rv_pkg::XLEN-1:0] store_data;
   logic mem_we, mem_re, mem_to_reg;
   logic [4:0] rd;
   logic reg_we;

   modport source (output valid, alu_result, store_data, mem_we, mem_re, mem_to_reg, rd,
                   reg_we);
   modport sink (input valid, alu_result, store_data, mem_we, mem_re, mem_to_reg, rd,
                 reg_we);
endinterface

// ==== source/instruction_fetch.sv ====
`timescale 1ns/1ps

module instruction_fetch #(
   parameter int IMEM_AW = 8
) (
   input logic clk,
   input logic reset,
   input logic run,
   input logic stall,
   input logic [31:0] insn_addr, // byte address
   input logic [31:0] insn_din,
   input logic insn_we,
   input logic [rv_pkg::XLEN-1:0] pc_in,
   input logic pc_in_en,
   output logic [rv_pkg::XLEN-1:0] pc_out,
   output logic [31:0] insn,
   output logic valid
);
   logic [31:0] imem [2**IMEM_AW];
   logic [rv_pkg::XLEN-1:0] pc;

   // loader port, only while the core is halted
   always_ff @(posedge clk) begin
      if (!run && insn_we)
         imem[insn_addr[IMEM_AW+1:2]] <= insn_din;
   end

   always_ff @(posedge clk) begin
      if (run && !stall) begin
         insn <= imem[pc[IMEM_AW+1:2]];
         pc_out <= pc;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
         valid <= 1'b0;
      end else if (run) begin
         if (pc_in_en)
            pc <= pc_in;
         else if (!stall)
            pc <= pc + 32'd4;
         valid <= !stall; // squashed fetch never issues
      end
   end

endmodule

// ==== source/decoder.sv ====
`timescale 1ns/1ps

module decoder (
   input logic clk,
   input logic reset,
   input logic run,
   input logic stall,
   input logic flush,
   input logic [31:0] insn,
   input logic [rv_pkg::XLEN-1:0] pc,
   input logic valid_in,
   input logic wb_we,
   input logic [4:0] wb_rd,
   input logic [rv_pkg::XLEN-1:0] wb_data,
   id_ex_if.source id_ex
);
   logic [rv_pkg::XLEN-1:0] rf [32];
   logic [6:0] opcode, funct7;
   logic [2:0] funct3;
   logic [4:0] rs1, rs2, rd;
   logic [rv_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm;
   logic [rv_pkg::XLEN-1:0] rs1_val, rs2_val;
   rv_pkg::alu_op_t alu_op;
   logic use_rs1, use_rs2, use_imm;
   logic reg_we, mem_re, mem_we, branch_en, jal_en, unknown_op;

   assign opcode = insn[6:0];
   assign rd = insn[11:7];
   assign funct3 = insn[14:12];
   assign rs1 = insn[19:15];
   assign rs2 = insn[24:20];
   assign funct7 = insn[31:25];

   assign imm_i = {{20{insn[31]}}, insn[31:20]};
   assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
   assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
   assign imm_u = {insn[31:12], 12'b0};
   assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

   always_comb begin
      alu_op = rv_pkg::ALU_ADD;
      imm = imm_i;
      {use_rs1, use_rs2, use_imm} = 3'b001;
      {reg_we, mem_re, mem_we, branch_en, jal_en, unknown_op} = 6'b0;
      case (opcode)
         rv_pkg::OPC_OP: begin
            {use_rs1, use_rs2, use_imm, reg_we} = 4'b1101;
            case ({funct7, funct3})
               {rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB}: alu_op = rv_pkg::ALU_ADD;
               {rv_pkg::F7_SUB, rv_pkg::F3_ADD_SUB}: alu_op = rv_pkg::ALU_SUB;
               {rv_pkg::F7_BASE, rv_pkg::F3_AND}: alu_op = rv_pkg::ALU_AND;
               {rv_pkg::F7_BASE, rv_pkg::F3_OR}: alu_op = rv_pkg::ALU_OR;
               {rv_pkg::F7_BASE, rv_pkg::F3_XOR}: alu_op = rv_pkg::ALU_XOR;
               {rv_pkg::F7_BASE, rv_pkg::F3_SLT}: alu_op = rv_pkg::ALU_SLT;
               default: unknown_op = 1'b1; // shifts, sltu
            endcase
         end
         rv_pkg::OPC_OP_IMM: begin
            {use_rs1, reg_we} = 2'b11;
            unknown_op = funct3 != rv_pkg::F3_ADD_SUB;
         end
         rv_pkg::OPC_LUI: begin
            imm = imm_u;
            alu_op = rv_pkg::ALU_PASS_B;
            reg_we = 1'b1;
         end
         rv_pkg::OPC_LOAD: begin
            {use_rs1, reg_we, mem_re} = 3'b111;
            unknown_op = funct3 != rv_pkg::F3_WORD;
         end
         rv_pkg::OPC_STORE: begin
            {use_rs1, use_rs2, mem_we} = 3'b111; // rs2 only as store data
            imm = imm_s;
            unknown_op = funct3 != rv_pkg::F3_WORD;
         end
         rv_pkg::OPC_BRANCH: begin
            {use_rs1, use_rs2, use_imm, branch_en} = 4'b1101;
            imm = imm_b;
            unknown_op = funct3 != rv_pkg::F3_BEQ && funct3 != rv_pkg::F3_BNE;
         end
         rv_pkg::OPC_JAL: begin
            imm = imm_j;
            {jal_en, reg_we} = 2'b11;
         end
         default: ; // anything else is a bubble
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset)
         rf[0] <= '0; // x0 holds zero
      else if (run && wb_we && wb_rd != 5'd0)
         rf[wb_rd] <= wb_data;
   end

   always_comb begin
      rs1_val = (wb_we && wb_rd == rs1 && rs1 != 5'd0) ? wb_data : rf[rs1]; // write-through
      rs2_val = (wb_we && wb_rd == rs2 && rs2 != 5'd0) ? wb_data : rf[rs2];
   end

   always_ff @(posedge clk) begin
      if (reset)
         id_ex.valid <= 1'b0;
      else if (run && flush)
         id_ex.valid <= 1'b0;
      else if (run && !stall)
         id_ex.valid <= valid_in;
   end

   always_ff @(posedge clk) begin
      if (run && !stall) begin
         id_ex.pc <= pc;
         id_ex.alu_op <= alu_op;
         id_ex.op_a <= rs1_val;
         id_ex.op_b <= use_imm ? imm : rs2_val;
         id_ex.imm <= imm;
         id_ex.store_data <= rs2_val;
         id_ex.rs1 <= use_rs1 ? rs1 : 5'd0; // keeps forwarding off unused fields
         id_ex.rs2 <= use_rs2 ? rs2 : 5'd0;
         id_ex.rd <= rd;
         id_ex.reg_we <= reg_we;
         id_ex.mem_re <= mem_re;
         id_ex.mem_we <= mem_we;
         id_ex.mem_to_reg <= mem_re;
         id_ex.branch_en <= branch_en;
         id_ex.branch_ne <= funct3 == rv_pkg::F3_BNE;
         id_ex.jal_en <= jal_en;
      end
   end

   a_x0_stays_zero: assert property (@(posedge clk) disable iff (reset)
      run && wb_we && wb_rd == 5'd0 |=> rs1 != 5'd0 || rs1_val == '0);

   a_known_op: assert property (@(posedge clk) disable iff (reset)
      run && valid_in && !stall && !flush |-> !unknown_op);

endmodule

// ==== source/executer.sv ====
`timescale 1ns/1ps

module executer (
   input logic clk,
   input logic reset,
   input logic run,
   input logic stall,
   input logic flush,
   id_ex_if.sink id_ex,
   input logic wb_we,
   input logic [4:0] wb_rd,
   input logic [rv_pkg::XLEN-1:0] wb_data,
   output logic [rv_pkg::XLEN-1:0] pc_in,
   output logic pc_in_en,
   ex_mem_if.source ex_mem
);
   rv_pkg::fwd_sel_t fwd_a, fwd_b, fwd_s;
   logic [rv_pkg::XLEN-1:0] a, b, s, alu_out;
   logic ex_ok, mem_ok, live, taken, redirect_q;

   function automatic rv_pkg::fwd_sel_t fwd_pick(input logic [4:0] rs, input logic [4:0] ex_rd,
                                                input logic [4:0] mem_rd, input logic ex_hit,
                                                input logic mem_hit);
      if (ex_hit && ex_rd == rs)
         return rv_pkg::FWD_EX;
      if (mem_hit && mem_rd == rs)
         return rv_pkg::FWD_MEM;
      return rv_pkg::FWD_REG;
   endfunction

   function automatic logic [rv_pkg::XLEN-1:0] fwd_mux(input rv_pkg::fwd_sel_t sel,
                                                      input logic [rv_pkg::XLEN-1:0] reg_val,
                                                      input logic [rv_pkg::XLEN-1:0] ex_val,
                                                      input logic [rv_pkg::XLEN-1:0] mem_val);
      return sel == rv_pkg::FWD_EX ? ex_val : sel == rv_pkg::FWD_MEM ? mem_val : reg_val;
   endfunction

   assign ex_ok = ex_mem.valid && ex_mem.reg_we && ex_mem.rd != 5'd0;
   assign mem_ok = wb_we && wb_rd != 5'd0;

   always_comb begin
      fwd_a = fwd_pick(id_ex.rs1, ex_mem.rd, wb_rd, ex_ok, mem_ok);
      fwd_s = fwd_pick(id_ex.rs2, ex_mem.rd, wb_rd, ex_ok, mem_ok);
      fwd_b = id_ex.mem_we ? rv_pkg::FWD_REG : fwd_s; // store: b is the offset
      a = fwd_mux(fwd_a, id_ex.op_a, ex_mem.alu_result, wb_data);
      b = fwd_mux(fwd_b, id_ex.op_b, ex_mem.alu_result, wb_data);
      s = fwd_mux(fwd_s, id_ex.store_data, ex_mem.alu_result, wb_data);
      case (id_ex.alu_op)
         rv_pkg::ALU_SUB: alu_out = a - b;
         rv_pkg::ALU_AND: alu_out = a & b;
         rv_pkg::ALU_OR: alu_out = a | b;
         rv_pkg::ALU_XOR: alu_out = a ^ b;
         rv_pkg::ALU_SLT: alu_out = {{(rv_pkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
         rv_pkg::ALU_PASS_B: alu_out = b;
         default: alu_out = a + b;
      endcase
   end

   assign live = id_ex.valid && !flush;
   assign taken = live && (id_ex.jal_en || (id_ex.branch_en && ((a == b) != id_ex.branch_ne)));
   assign pc_in_en = redirect_q && run;

   always_ff @(posedge clk) begin
      if (reset) begin
         ex_mem.valid <= 1'b0;
         redirect_q <= 1'b0;
      end else if (run && (flush || !stall)) begin
         ex_mem.valid <= live;
         redirect_q <= taken;
      end
   end

   always_ff @(posedge clk) begin
      if (run && !stall) begin
         pc_in <= id_ex.pc + id_ex.imm;
         ex_mem.alu_result <= id_ex.jal_en ? id_ex.pc + 32'd4 : alu_out; // link for jal
         ex_mem.store_data <= s;
         {ex_mem.mem_we, ex_mem.mem_re, ex_mem.mem_to_reg} <=
            {id_ex.mem_we, id_ex.mem_re, id_ex.mem_to_reg};
         ex_mem.rd <= id_ex.rd;
         ex_mem.reg_we <= id_ex.reg_we;
      end
   end

   a_redirect_pulse: assert property (@(posedge clk) disable iff (reset)
      pc_in_en |-> run ##1 !pc_in_en);

   // no interlock, so a load result is never wanted by the very next insn
   a_no_load_use: assert property (@(posedge clk) disable iff (reset)
      run && live && ex_mem.mem_re |->
         fwd_a != rv_pkg::FWD_EX && fwd_b != rv_pkg::FWD_EX && fwd_s != rv_pkg::FWD_EX);

endmodule

// ==== source/data_memory.sv ====
`timescale 1ns/1ps

module data_memory #(
   parameter int DMEM_AW = 10
) (
   input logic clk,
   input logic reset,
   input logic run,
   input logic [rv_pkg::XLEN-1:0] data_addr, // byte address
   input logic [rv_pkg::XLEN-1:0] data_din,
   input logic data_we,
   ex_mem_if.sink ex_mem,
   output logic wb_we,
   output logic [4:0] wb_rd,
   output logic [rv_pkg::XLEN-1:0] wb_data,
   output logic [rv_pkg::XLEN-1:0] uart_dout,
   output logic uart_we
);
   logic [rv_pkg::XLEN-1:0] dmem [2**DMEM_AW];
   logic [rv_pkg::XLEN-1:0] load_data;
   logic [DMEM_AW-1:0] word;
   logic is_uart, store_en, uart_q;

   assign word = ex_mem.alu_result[DMEM_AW+1:2];
   assign is_uart = ex_mem.alu_result == rv_pkg::UART_ADDR;
   assign store_en = run && ex_mem.valid && ex_mem.mem_we;
   assign load_data = ex_mem.mem_re ? dmem[word] : '0;

   // loader and core share the write port
   always_ff @(posedge clk) begin
      if (!run && data_we)
         dmem[data_addr[DMEM_AW+1:2]] <= data_din;
      else if (store_en && !is_uart)
         dmem[word] <= ex_mem.store_data;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_we <= 1'b0;
         uart_q <= 1'b0;
      end else if (run) begin
         wb_we <= ex_mem.valid && ex_mem.reg_we;
         uart_q <= store_en && is_uart;
      end
   end

   always_ff @(posedge clk) begin
      if (run) begin
         wb_rd <= ex_mem.rd;
         wb_data <= ex_mem.mem_to_reg ? load_data : ex_mem.alu_result;
      end
      if (store_en && is_uart)
         uart_dout <= ex_mem.store_data;
   end

   // a pending byte waits out a pause
   assign uart_we = uart_q && run;

   a_uart_single: assert property (@(posedge clk) disable iff (reset)
      uart_we |=> !uart_we);

endmodule

// ==== source/core.sv ====
`timescale 1ns/1ps

module core #(
   parameter int IMEM_AW = 8,
   parameter int DMEM_AW = 10
) (
   input logic clk,
   input logic reset,
   input logic run,
   input logic [31:0] insn_addr,
   input logic [31:0] insn_din,
   input logic insn_we,
   input logic [31:0] data_addr,
   input logic [31:0] data_din,
   input logic data_we,
   output logic [31:0] uart_dout,
   output logic uart_we
);
   logic [31:0] insn;
   logic [rv_pkg::XLEN-1:0] pc_if, pc_in, wb_data;
   logic [4:0] wb_rd;
   logic valid_if, wb_we, pc_in_en, pc_in_en_q, redirect_first;
   logic stall_if, stall_id, stall_ex, flush;

   id_ex_if id_ex ();
   ex_mem_if ex_mem ();

   always_ff @(posedge clk) begin
      if (reset)
         pc_in_en_q <= 1'b0;
      else if (run)
         pc_in_en_q <= pc_in_en;
   end

   // first cycle of a redirect squashes everything younger
   assign redirect_first = pc_in_en && !pc_in_en_q;

   always_comb begin
      stall_if = redirect_first;
      stall_id = redirect_first;
      stall_ex = redirect_first;
      flush = redirect_first;
   end

   instruction_fetch #(.IMEM_AW(IMEM_AW)) if_i (.clk, .reset, .run, .stall(stall_if),
      .insn_addr, .insn_din, .insn_we, .pc_in, .pc_in_en, .pc_out(pc_if), .insn,
      .valid(valid_if));

   decoder id_i (.clk, .reset, .run, .stall(stall_id), .flush, .insn, .pc(pc_if),
      .valid_in(valid_if), .wb_we, .wb_rd, .wb_data, .id_ex(id_ex.source));

   executer ex_i (.clk, .reset, .run, .stall(stall_ex), .flush, .id_ex(id_ex.sink),
      .wb_we, .wb_rd, .wb_data, .pc_in, .pc_in_en, .ex_mem(ex_mem.source));

   data_memory #(.DMEM_AW(DMEM_AW)) mem_i (.clk, .reset, .run, .data_addr, .data_din,
      .data_we, .ex_mem(ex_mem.sink), .wb_we, .wb_rd, .wb_data, .uart_dout, .uart_we);

endmodule

// ==== verification/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;
   localparam int CYCLE_LIMIT = 3000;
   localparam logic [31:0] MARKER = 32'h0000_05A5;

   logic clk = 1'b0;
   logic reset, run, insn_we, data_we, uart_we;
   logic [31:0] insn_addr, insn_din, data_addr, data_din, uart_dout;

   logic [31:0] expected [$];
   logic [31:0] exp_head = '0;
   logic exp_ok = 1'b0;
   logic [31:0] load_ptr;
   int cycles = 0;
   int check_errors = 0;
   int run_errors = 0;

   core dut (.clk, .reset, .run, .insn_addr, .insn_din, .insn_we, .data_addr, .data_din,
      .data_we, .uart_dout, .uart_we);

   always #50 clk = ~clk;

   function automatic logic [31:0] op_reg(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, rs2);
      return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
   endfunction

   function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
      return {imm, rs1, rv_pkg::F3_ADD_SUB, rd, rv_pkg::OPC_OP_IMM};
   endfunction

   function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
      return {imm, rd, rv_pkg::OPC_LUI};
   endfunction

   function automatic logic [31:0] lw(input logic [4:0] rd, rs1, input logic [11:0] off);
      return {off, rs1, rv_pkg::F3_WORD, rd, rv_pkg::OPC_LOAD};
   endfunction

   function automatic logic [31:0] sw(input logic [4:0] rs2, rs1, input logic [11:0] off);
      return {off[11:5], rs2, rs1, rv_pkg::F3_WORD, off[4:0], rv_pkg::OPC_STORE};
   endfunction

   function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                          input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
   endfunction

   function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
   endfunction

   // lui part, rounded so that the sign-extended addi low part lands exactly
   function automatic logic [19:0] upper_bits(input logic [31:0] value);
      return 20'((value + 32'h800) >> 12);
   endfunction

   task automatic put_insn(input logic [31:0] word);
      insn_addr = load_ptr;
      insn_din = word;
      insn_we = 1'b1;
      @(posedge clk);
      #10;
      insn_we = 1'b0;
      load_ptr = load_ptr + 32'd4;
   endtask

   task automatic preload_word(input logic [31:0] addr, input logic [31:0] value);
      data_addr = addr;
      data_din = value;
      data_we = 1'b1;
      @(posedge clk);
      #10;
      data_we = 1'b0;
   endtask

   // x1 always holds the uart address
   task automatic store_to_uart(input logic [4:0] rs, input logic [31:0] value);
      put_insn(sw(rs, 5'd1, 12'd0));
      put_insn(addi(5'd0, 5'd0, 12'd0)); // uart pulses never back to back
      expected.push_back(value);
   endtask

   task automatic put_halt();
      put_insn(jal(5'd0, 21'd0)); // jump to self
      put_insn(addi(5'd0, 5'd0, 12'd0)); // squashed fetches land on nops
      put_insn(addi(5'd0, 5'd0, 12'd0));
   endtask

   task automatic restart();
      run = 1'b0;
      reset = 1'b1;
      repeat (2) @(posedge clk);
      #10;
      reset = 1'b0;
      load_ptr = '0;
   endtask

   task automatic run_program(input bit pause);
      int total;
      int hold;
      bit paused;
      total = expected.size();
      paused = 1'b0;
      run = 1'b1;
      while (expected.size() > 0) begin
         @(posedge clk);
         #10;
         if (pause && !paused && expected.size() == total - 2) begin
            paused = 1'b1;
            hold = $urandom_range(20, 3);
            run = 1'b0;
            repeat (hold) @(posedge clk);
            #10;
            run = 1'b1;
         end
      end
      repeat (8) @(posedge clk); // room for a stray uart write
      #10;
      run = 1'b0;
   endtask

   task automatic alu_program();
      logic [31:0] a, b, r4, r5, r6, r7, r8, r9;
      a = $urandom();
      b = $urandom();
      r4 = a + b;
      r5 = a - r4;
      r6 = r5 & r4;
      r7 = r6 | b;
      r8 = r7 ^ r5;
      r9 = {31'd0, $signed(r8) < $signed(r7)};
      restart();
      put_insn(lui(5'd1, 20'h0000F));
      put_insn(lui(5'd2, upper_bits(a)));
      put_insn(addi(5'd2, 5'd2, a[11:0]));
      put_insn(lui(5'd3, upper_bits(b)));
      put_insn(addi(5'd3, 5'd3, b[11:0]));
      put_insn(op_reg(rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB, 5'd4, 5'd2, 5'd3));
      put_insn(op_reg(rv_pkg::F7_SUB, rv_pkg::F3_ADD_SUB, 5'd5, 5'd2, 5'd4));
      put_insn(op_reg(rv_pkg::F7_BASE, rv_pkg::F3_AND, 5'd6, 5'd5, 5'd4));
      put_insn(op_reg(rv_pkg::F7_BASE, rv_pkg::F3_OR, 5'd7, 5'd6, 5'd3));
      put_insn(op_reg(rv_pkg::F7_BASE, rv_pkg::F3_XOR, 5'd8, 5'd7, 5'd5));
      put_insn(op_reg(rv_pkg::F7_BASE, rv_pkg::F3_SLT, 5'd9, 5'd8, 5'd7));
      store_to_uart(5'd9, r9); // store data straight from ex
      store_to_uart(5'd8, r8);
      store_to_uart(5'd7, r7);
      store_to_uart(5'd6, r6);
      store_to_uart(5'd5, r5);
      store_to_uart(5'd4, r4);
      put_halt();
      run_program(1'b0);
   endtask

   task automatic memory_program();
      logic [31:0] d0, d1;
      d0 = $urandom();
      d1 = $urandom();
      restart();
      preload_word(32'h100, d0);
      preload_word(32'h104, d1);
      preload_word(32'h200, ~(d0 + d1)); // stale, must be overwritten
      put_insn(lui(5'd1, 20'h0000F));
      put_insn(addi(5'd10, 5'd0, 12'h100));
      put_insn(lw(5'd11, 5'd10, 12'd0));
      put_insn(lw(5'd12, 5'd10, 12'd4));
      put_insn(addi(5'd14, 5'd0, 12'h200)); // spacer after the load
      put_insn(op_reg(rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB, 5'd13, 5'd11, 5'd12));
      put_insn(sw(5'd13, 5'd14, 12'd0));
      put_insn(lw(5'd15, 5'd14, 12'd0));
      put_insn(addi(5'd0, 5'd0, 12'd0));
      store_to_uart(5'd15, d0 + d1);
      put_halt();
      run_program(1'b0);
   endtask

   task automatic loop_program(input bit pause);
      logic [31:0] post;
      post = $urandom_range(1000, 0);
      restart();
      put_insn(lui(5'd1, 20'h0000F));
      put_insn(addi(5'd20, 5'd0, 12'd5));
      put_insn(addi(5'd21, 5'd0, MARKER[11:0]));
      put_insn(sw(5'd20, 5'd1, 12'd0)); // loop top at 12
      put_insn(addi(5'd20, 5'd20, -12'd1));
      put_insn(branch(rv_pkg::F3_BNE, 5'd20, 5'd0, -13'd8));
      put_insn(branch(rv_pkg::F3_BEQ, 5'd20, 5'd0, 13'd8));
      put_insn(sw(5'd21, 5'd1, 12'd0));
      put_insn(addi(5'd22, 5'd0, post[11:0]));
      put_insn(sw(5'd22, 5'd1, 12'd0));
      put_insn(jal(5'd23, 21'd8)); // at 40, link is 44
      put_insn(sw(5'd21, 5'd1, 12'd0));
      put_insn(sw(5'd23, 5'd1, 12'd0));
      put_halt();
      for (int n = 5; n >= 1; n--)
         expected.push_back(32'(n));
      expected.push_back(post);
      expected.push_back(32'd44);
      run_program(pause);
   endtask

   // head of the queue, refreshed mid-cycle so it is stable at the edge
   always @(negedge clk) begin
      exp_ok = expected.size() > 0;
      exp_head = exp_ok ? expected[0] : 32'd0;
   end

   always @(posedge clk) begin
      if (uart_we && expected.size() > 0)
         void'(expected.pop_front());
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, %0d uart values still expected", cycles,
            expected.size());
         $display("errors: %0d from checks, %0d other", check_errors, run_errors + 1);
         $display("Verification failed");
         $finish;
      end
   end

   a_uart_value: assert property (@(posedge clk) disable iff (reset)
      uart_we && exp_ok |-> uart_dout == exp_head)
      else begin
         check_errors = check_errors + 1;
         $display("** Error at %0t: uart_dout expected %h, got %h", $time,
            $sampled(exp_head), $sampled(uart_dout));
      end

   a_uart_wanted: assert property (@(posedge clk) disable iff (reset) uart_we |-> exp_ok)
      else begin
         check_errors = check_errors + 1;
         $display("uart_we pulsed at %0t with no value expected", $time);
      end

   a_no_marker: assert property (@(posedge clk) disable iff (reset)
      uart_we |-> uart_dout != MARKER)
      else begin
         check_errors = check_errors + 1;
         $display("a skipped store reached the uart at %0t", $time);
      end

   // quiet while reset, loading or paused
   a_quiet: assert property (@(posedge clk) reset || !run |-> !uart_we)
      else begin
         check_errors = check_errors + 1;
         $display("uart_we rose at %0t while the core was reset or halted", $time);
      end

   initial begin
      void'($urandom(41637));
      reset = 1'b1;
      run = 1'b0;
      insn_we = 1'b0;
      data_we = 1'b0;
      insn_addr = '0;
      insn_din = '0;
      data_addr = '0;
      data_din = '0;
      load_ptr = '0;
      alu_program();
      memory_program();
      loop_program(1'b0);
      loop_program(1'b1);
      if (expected.size() > 0) begin
         run_errors = run_errors + 1;
         $display("%0d expected uart values never appeared", expected.size());
      end
      $display("errors: %0d from checks, %0d other", check_errors, run_errors);
      if (check_errors == 0 && run_errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// ==== tb.f ====
source/rv_pkg.sv
source/pipe_if.sv
source/instruction_fetch.sv
source/decoder.sv
source/executer.sv
source/data_memory.sv
source/core.sv
verification/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator from tb.f, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module core_tb -f tb.f -o core_sim || exit 1
out=$(./obj_dir/core_sim)
echo "$out"
echo "$out" | grep -q "Verification passed" && exit 0 || exit 1
